// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    // Widths and sizes
    localparam int XLEN            = 64;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int IMEM_ADDR_WIDTH = 10;    // Word index, 4 KB of program
    localparam int DMEM_ADDR_WIDTH = 10;    // Doubleword index
    localparam int DMEM_DEPTH      = 1024;  // 8 KB of data

    // --------------------
    // Opcodes
    localparam logic [6:0] OPCODE_RTYPE  = 7'b0110011;  // add, sub, and, or
    localparam logic [6:0] OPCODE_ITYPE  = 7'b0010011;  // addi only
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;  // ld
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;  // sd
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;  // beq

    // --------------------
    // ALU operation codes
    localparam logic [3:0] ALU_AND = 4'b0000;
    localparam logic [3:0] ALU_OR  = 4'b0001;
    localparam logic [3:0] ALU_ADD = 4'b0010;
    localparam logic [3:0] ALU_SUB = 4'b0110;

    // Forwarding selects
    localparam logic [1:0] FWD_NONE = 2'b00;    // Value read in decode
    localparam logic [1:0] FWD_MEM  = 2'b10;    // EX/MEM result
    localparam logic [1:0] FWD_WB   = 2'b01;    // Writeback value

    // --------------------
    // Vector types
    typedef logic [XLEN-1:0]            word_t;
    typedef logic [63:0]                pc_t;
    typedef logic [31:0]                inst_t;
    typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;
    typedef logic [IMEM_ADDR_WIDTH-1:0] imem_addr_t;
    typedef logic [3:0]                 alu_ctrl_t;
    typedef logic [1:0]                 alu_op_t;   // Bit 1 R-type, bit 0 branch
    typedef logic [1:0]                 fwd_sel_t;

endpackage

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage (
    input  logic               clk,
    input  logic               reset_b,
    input  logic               pc_write,        // Low while decode stalls
    input  logic               if_stall,
    input  logic               if_flush,        // Kill the word just fetched
    input  logic               branch_taken,
    input  cpu_pkg::pc_t       branch_target,
    output cpu_pkg::imem_addr_t imem_addr,
    input  cpu_pkg::inst_t     inst,            // Same cycle as imem_addr
    output cpu_pkg::pc_t       id_pc,
    output cpu_pkg::inst_t     id_inst
);
    import cpu_pkg::*;

    pc_t pc;
    pc_t pc_next;

    // Next PC select
    assign pc_next = branch_taken ? branch_target : pc + 64'd4;

    // Word index into instruction memory
    assign imem_addr = pc[IMEM_ADDR_WIDTH+1:2];

    // --------------------
    // Program counter
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            pc <= '0;
        end else if (pc_write) begin
            pc <= pc_next;
        end
    end

    // --------------------
    // IF/ID register
    // Flush beats stall, zero word is a no-op
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            id_pc   <= '0;
            id_inst <= '0;
        end else if (if_flush) begin
            id_pc   <= '0;
            id_inst <= '0;
        end else if (!if_stall) begin
            id_pc   <= pc;
            id_inst <= inst;
        end
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic                clk,
    input  logic                reset_b,
    input  cpu_pkg::pc_t        id_pc,
    input  cpu_pkg::inst_t      id_inst,
    output cpu_pkg::reg_addr_t  rs1,
    output cpu_pkg::reg_addr_t  rs2,
    input  cpu_pkg::word_t      rs1_data,
    input  cpu_pkg::word_t      rs2_data,
    input  cpu_pkg::reg_addr_t  mem_rd,         // From EX/MEM, branch hazard
    input  logic                mem_reg_write,
    output logic                pc_write,
    output logic                if_stall,
    output logic                if_flush,
    output logic                branch_taken,
    output cpu_pkg::pc_t        branch_target,
    // ID/EX register
    output cpu_pkg::word_t      ex_rs1_data,
    output cpu_pkg::word_t      ex_rs2_data,
    output cpu_pkg::word_t      ex_imm,
    output cpu_pkg::reg_addr_t  ex_rs1,
    output cpu_pkg::reg_addr_t  ex_rs2,
    output cpu_pkg::reg_addr_t  ex_rd,
    output logic [2:0]          ex_funct3,
    output logic                ex_funct7_5,
    output logic                ex_alu_src,
    output logic                ex_mem_read,
    output logic                ex_mem_write,
    output logic                ex_reg_write,
    output logic                ex_mem_to_reg,
    output cpu_pkg::alu_op_t    ex_alu_op
);
    import cpu_pkg::*;

    logic [6:0]  opcode;
    logic        is_rtype, is_itype, branch;
    logic        mem_read, mem_write, reg_write, alu_src;
    alu_op_t     alu_op;
    reg_addr_t   rd;
    logic [11:0] imm12;
    word_t       imm;
    logic        load_use, branch_hazard, stall;

    // --------------------
    // Main control
    assign opcode    = id_inst[6:0];
    assign is_rtype  = (opcode == OPCODE_RTYPE);
    assign is_itype  = (opcode == OPCODE_ITYPE);
    assign branch    = (opcode == OPCODE_BRANCH);
    assign mem_read  = (opcode == OPCODE_LOAD);
    assign mem_write = (opcode == OPCODE_STORE);
    assign reg_write = is_rtype | is_itype | mem_read;
    assign alu_src   = is_itype | mem_read | mem_write;     // Immediate operand
    assign alu_op    = {is_rtype, branch};

    // Register fields
    assign rs1 = id_inst[19:15];
    assign rs2 = id_inst[24:20];
    assign rd  = id_inst[11:7];

    // --------------------
    // Immediate, B, S or I format
    always_comb begin
        if (branch) begin
            imm12 = {id_inst[31], id_inst[7], id_inst[30:25], id_inst[11:8]};
        end else if (mem_write) begin
            imm12 = {id_inst[31:25], id_inst[11:7]};
        end else begin
            imm12 = id_inst[31:20];                 // ld and addi
        end
    end
    assign imm = {{(XLEN-12){imm12[11]}}, imm12};

    // Branch target, halfword offset
    assign branch_target = id_pc + {imm[62:0], 1'b0};

    // --------------------
    // Hazard detection
    // Load result not ready until after MEM
    assign load_use = ex_mem_read & ((ex_rd == rs1) | (ex_rd == rs2));

    // beq compares in decode, so wait for any pending writer
    assign branch_hazard = branch &
        ((ex_reg_write & (ex_rd != '0) & ((ex_rd == rs1) | (ex_rd == rs2))) |
         (mem_reg_write & (mem_rd != '0) & ((mem_rd == rs1) | (mem_rd == rs2))));

    assign stall        = load_use | branch_hazard;
    assign pc_write     = ~stall;
    assign if_stall     = stall;
    assign branch_taken = branch & ~stall & (rs1_data == rs2_data);
    assign if_flush     = branch_taken;     // Drop the word behind beq

    // --------------------
    // ID/EX register, bubble on stall
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            ex_rs1_data <= '0;
            ex_rs2_data <= '0;
            ex_imm <= '0;
            ex_rs1 <= '0;
            ex_rs2 <= '0;
            ex_rd <= '0;
            ex_funct3 <= '0;
            ex_funct7_5 <= 1'b0;
            ex_alu_src <= 1'b0;
            ex_mem_read <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_alu_op <= '0;
        end else begin
            ex_rs1_data <= stall ? '0 : rs1_data;
            ex_rs2_data <= stall ? '0 : rs2_data;
            ex_imm <= stall ? '0 : imm;
            ex_rs1 <= stall ? '0 : rs1;
            ex_rs2 <= stall ? '0 : rs2;
            ex_rd <= stall ? '0 : rd;
            ex_funct3 <= stall ? '0 : id_inst[14:12];
            ex_funct7_5 <= ~stall & id_inst[30];        // sub vs add
            ex_alu_src <= ~stall & alu_src;
            ex_mem_read <= ~stall & mem_read;
            ex_mem_write <= ~stall & mem_write;
            ex_reg_write <= ~stall & reg_write;
            ex_mem_to_reg <= ~stall & mem_read;         // Only loads write from memory
            ex_alu_op <= stall ? '0 : alu_op;
        end
    end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ns

module regfile (
    input  logic               clk,
    input  logic               reset_b,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::reg_addr_t rd,
    input  logic               rd_write,
    input  cpu_pkg::word_t     rd_data,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data
);
    import cpu_pkg::*;

    word_t regs [32];

    // x0 never written, stays zero from reset
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // Write-through, decode sees the writeback of the same cycle
    assign rs1_data = (rd_write && rd != '0 && rd == rs1) ? rd_data : regs[rs1];
    assign rs2_data = (rd_write && rd != '0 && rd == rs2) ? rd_data : regs[rs2];

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
    input  logic               clk,
    input  logic               reset_b,
    // ID/EX register
    input  cpu_pkg::word_t     ex_rs1_data,
    input  cpu_pkg::word_t     ex_rs2_data,
    input  cpu_pkg::word_t     ex_imm,
    input  cpu_pkg::reg_addr_t ex_rs1,
    input  cpu_pkg::reg_addr_t ex_rs2,
    input  cpu_pkg::reg_addr_t ex_rd,
    input  logic [2:0]         ex_funct3,
    input  logic               ex_funct7_5,
    input  logic               ex_alu_src,
    input  logic               ex_mem_read,
    input  logic               ex_mem_write,
    input  logic               ex_reg_write,
    input  logic               ex_mem_to_reg,
    input  cpu_pkg::alu_op_t   ex_alu_op,
    // Writeback, for forwarding
    input  cpu_pkg::reg_addr_t wb_rd,
    input  logic               wb_write,
    input  cpu_pkg::word_t     wb_data,
    // EX/MEM register
    output cpu_pkg::word_t     mem_alu_result,
    output cpu_pkg::word_t     mem_store_data,
    output cpu_pkg::reg_addr_t mem_rd,
    output logic               mem_mem_read,
    output logic               mem_mem_write,
    output logic               mem_reg_write,
    output logic               mem_mem_to_reg
);
    import cpu_pkg::*;

    alu_ctrl_t alu_ctrl;
    fwd_sel_t  fwd_a, fwd_b;
    word_t     op_a, op_b;      // Forwarded register values
    word_t     alu_in2, alu_result;

    // Newest producer wins and x0 is never forwarded
    function automatic fwd_sel_t fwd_select(input reg_addr_t rs);
        if (mem_reg_write && mem_rd != '0 && mem_rd == rs) begin
            return FWD_MEM;
        end else if (wb_write && wb_rd != '0 && wb_rd == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    // --------------------
    // ALU control
    always_comb begin
        if (ex_alu_op[1]) begin
            case (ex_funct3)
                3'b111:  alu_ctrl = ALU_AND;
                3'b110:  alu_ctrl = ALU_OR;
                default: alu_ctrl = ex_funct7_5 ? ALU_SUB : ALU_ADD;
            endcase
        end else begin
            alu_ctrl = ex_alu_op[0] ? ALU_SUB : ALU_ADD;    // addi, ld, sd add
        end
    end

    // --------------------
    // Forwarding
    always_comb begin
        fwd_a = fwd_select(ex_rs1);
        fwd_b = fwd_select(ex_rs2);
    end

    assign op_a = (fwd_a == FWD_MEM) ? mem_alu_result :
                  (fwd_a == FWD_WB)  ? wb_data : ex_rs1_data;
    assign op_b = (fwd_b == FWD_MEM) ? mem_alu_result :
                  (fwd_b == FWD_WB)  ? wb_data : ex_rs2_data;

    assign alu_in2 = ex_alu_src ? ex_imm : op_b;

    // ALU
    always_comb begin
        case (alu_ctrl)
            ALU_AND: alu_result = op_a & alu_in2;
            ALU_OR:  alu_result = op_a | alu_in2;
            ALU_SUB: alu_result = op_a - alu_in2;
            default: alu_result = op_a + alu_in2;
        endcase
    end

    // --------------------
    // EX/MEM register
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            mem_alu_result <= '0;
            mem_store_data <= '0;
            mem_rd <= '0;
            mem_mem_read <= 1'b0;
            mem_mem_write <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_mem_to_reg <= 1'b0;
        end else begin
            mem_alu_result <= alu_result;
            mem_store_data <= op_b;         // Store data from the forwarded rs2
            mem_rd <= ex_rd;
            mem_mem_read <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
            mem_reg_write <= ex_reg_write;
            mem_mem_to_reg <= ex_mem_to_reg;
        end
    end

endmodule

// ==== verilog/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage (
    input  logic               clk,
    input  logic               reset_b,
    input  cpu_pkg::word_t     mem_alu_result,  // Address or result
    input  cpu_pkg::word_t     mem_store_data,
    input  cpu_pkg::reg_addr_t mem_rd,
    input  logic               mem_mem_read,
    input  logic               mem_mem_write,
    input  logic               mem_reg_write,
    input  logic               mem_mem_to_reg,
    output logic               wb_write,
    output cpu_pkg::reg_addr_t wb_rd,
    output cpu_pkg::word_t     wb_data
);
    import cpu_pkg::*;

    word_t dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_WIDTH-1:0] dmem_addr;
    word_t load_data;
    word_t wb_alu_result, wb_load_data;
    logic  wb_mem_to_reg;

    // Doubleword index from byte address
    assign dmem_addr = mem_alu_result[DMEM_ADDR_WIDTH+2:3];

    // --------------------
    // Data memory, write at the edge
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_mem_write) begin
            dmem[dmem_addr] <= mem_store_data;
        end
    end

    assign load_data = mem_mem_read ? dmem[dmem_addr] : '0;   // Combinational read

    // --------------------
    // MEM/WB register
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wb_write <= 1'b0;
            wb_rd <= '0;
            wb_alu_result <= '0;
            wb_load_data <= '0;
            wb_mem_to_reg <= 1'b0;
        end else begin
            wb_write <= mem_reg_write;
            wb_rd <= mem_rd;
            wb_alu_result <= mem_alu_result;
            wb_load_data <= load_data;
            wb_mem_to_reg <= mem_mem_to_reg;
        end
    end

    // Writeback select
    assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

// ==== verilog/pipeline_cpu.sv ====
`timescale 1ns/1ns

module pipeline_cpu (
    input  logic                clk,
    input  logic                reset_b,
    output cpu_pkg::imem_addr_t imem_addr,  // PC bits 11:2
    input  cpu_pkg::inst_t      inst,
    output logic                wb_write,   // One cycle per written result
    output cpu_pkg::reg_addr_t  wb_rd,
    output cpu_pkg::word_t      wb_data
);
    import cpu_pkg::*;

    // --------------------
    // Fetch and decode handshake
    logic      pc_write, if_stall, if_flush, branch_taken;
    pc_t       branch_target;
    pc_t       id_pc;
    inst_t     id_inst;

    // Register file read port
    reg_addr_t rs1, rs2;
    word_t     rs1_data, rs2_data;

    // --------------------
    // ID/EX
    word_t     ex_rs1_data, ex_rs2_data, ex_imm;
    reg_addr_t ex_rs1, ex_rs2, ex_rd;
    logic [2:0] ex_funct3;
    logic      ex_funct7_5, ex_alu_src, ex_mem_read, ex_mem_write;
    logic      ex_reg_write, ex_mem_to_reg;
    alu_op_t   ex_alu_op;

    // EX/MEM
    word_t     mem_alu_result, mem_store_data;
    reg_addr_t mem_rd;
    logic      mem_mem_read, mem_mem_write, mem_reg_write, mem_mem_to_reg;

    // --------------------
    // Stages, port names match the nets above
    fetch_stage fetch_stage_inst (.*);

    decode_stage decode_stage_inst (.*);

    execute_stage execute_stage_inst (.*);

    memory_stage memory_stage_inst (.*);

    // Written from MEM/WB
    regfile regfile_inst (
        .clk      (clk),
        .reset_b  (reset_b),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (wb_rd),
        .rd_write (wb_write),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

// ==== bench/tb_programs.svh ====
// Test table, one row per program
localparam int NUM_TESTS  = 5;
localparam int PROG_LEN   = 10;     // Words per program, zero padded
localparam int MAX_WRITES = 6;

string test_name [NUM_TESTS] = '{
    "alu_chain", "store_load", "load_use", "branch_taken_not", "branch_stall"
};

// --------------------
// Programs, assembly in the comment above each row
inst_t program_table [NUM_TESTS][PROG_LEN] = '{
    // addi x1,x0,13  add x2,x1,x1  sub x3,x2,x1  and x4,x3,x2  or x5,x4,x2  sub x6,x0,x5
    '{32'h00D00093, 32'h00108133, 32'h401101B3, 32'h0021F233, 32'h002262B3,
      32'h40500333, 32'h0, 32'h0, 32'h0, 32'h0},
    // addi x1,x0,64  addi x2,x0,-1234  addi x3,x0,48  sd x2,16(x1)  ld x4,32(x3)
    '{32'h04000093, 32'hB2E00113, 32'h03000193, 32'h0020B823, 32'h0201B203,
      32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
    // addi x1,x0,100  sd x1,8(x0)  ld x2,8(x0)  add x3,x2,x1
    '{32'h06400093, 32'h00103423, 32'h00803103, 32'h001101B3, 32'h0,
      32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
    // addi x1,7  addi x2,7  addi x3,9  beq x1,x3,+8  addi x4,1
    // beq x1,x2,+8  addi x5,2  addi x6,3
    '{32'h00700093, 32'h00700113, 32'h00900193, 32'h00308463, 32'h00100213,
      32'h00208463, 32'h00200293, 32'h00300313, 32'h0, 32'h0},
    // addi x1,5  addi x2,5  beq x1,x2,+12  addi x3,1  addi x4,2  addi x5,3
    // addi x6,3  beq x6,x0,+8  addi x7,6  addi x8,8
    '{32'h00500093, 32'h00500113, 32'h00208663, 32'h00100193, 32'h00200213,
      32'h00300293, 32'h00300313, 32'h00030463, 32'h00600393, 32'h00800413}
};

// --------------------
// Expected writebacks in program order
int write_count [NUM_TESTS] = '{6, 4, 3, 5, 6};

reg_addr_t exp_rd [NUM_TESTS][MAX_WRITES] = '{
    '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6},
    '{5'd1, 5'd2, 5'd3, 5'd4, 5'd0, 5'd0},
    '{5'd1, 5'd2, 5'd3, 5'd0, 5'd0, 5'd0},
    '{5'd1, 5'd2, 5'd3, 5'd4, 5'd6, 5'd0},     // x5 skipped by taken beq
    '{5'd1, 5'd2, 5'd5, 5'd6, 5'd7, 5'd8}      // x3, x4 skipped
};

word_t exp_data [NUM_TESTS][MAX_WRITES] = '{
    '{64'd13, 64'd26, 64'd13, 64'd8, 64'd26, 64'hFFFF_FFFF_FFFF_FFE6},
    '{64'd64, 64'hFFFF_FFFF_FFFF_FB2E, 64'd48, 64'hFFFF_FFFF_FFFF_FB2E, 64'd0, 64'd0},
    '{64'd100, 64'd100, 64'd200, 64'd0, 64'd0, 64'd0},
    '{64'd7, 64'd7, 64'd9, 64'd1, 64'd3, 64'd0},
    '{64'd5, 64'd5, 64'd3, 64'd3, 64'd6, 64'd8}
};

// ==== bench/tb_pipeline_cpu.sv ====
`timescale 1ns/1ns

module tb_pipeline_cpu;
    import cpu_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;    // After the rising edge
    localparam int WB_TIMEOUT   = 50;   // Cycles per writeback
    localparam int QUIET_CYCLES = 20;

    logic       clk;
    logic       reset_b;
    imem_addr_t imem_addr;
    inst_t      inst;
    logic       wb_write;
    reg_addr_t  wb_rd;
    word_t      wb_data;

    inst_t imem [1 << IMEM_ADDR_WIDTH];    // Holds the program with zeros past the end

    `include "tb_programs.svh"

    pipeline_cpu pipeline_cpu_inst (
        .clk       (clk),
        .reset_b   (reset_b),
        .imem_addr (imem_addr),
        .inst      (inst),
        .wb_write  (wb_write),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    assign inst = imem[imem_addr];     // Combinational fetch

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // Checks
    task automatic abort_run(input string reason);
        $display("test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_rd(input string name, input reg_addr_t expected,
                            input reg_addr_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: wb_rd expected x%0d, actual x%0d", name, expected, actual);
            abort_run("writeback register mismatch");
        end
    endtask

    task automatic check_data(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: wb_data expected %h, actual %h", name, expected, actual);
            abort_run("writeback data mismatch");
        end
    endtask

    // Enters at a falling edge and returns at the one showing a write
    task automatic wait_writeback(input string name);
        int cycles;
        cycles = 0;
        while (wb_write !== 1'b1) begin
            if (cycles == WB_TIMEOUT) begin
                $display("No writeback in %s within %0d cycles", name, WB_TIMEOUT);
                abort_run("writeback timeout");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Program swapped in while reset is held
    task automatic reset_with_program(input int t);
        @(posedge clk);
        #DRIVE_DELAY;
        reset_b = 1'b0;
        foreach (imem[i]) begin
            imem[i] = '0;
        end
        for (int j = 0; j < PROG_LEN; j++) begin
            imem[j] = program_table[t][j];
        end
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset_b = 1'b1;
    endtask

    // --------------------
    // Test loop
    initial begin
        reset_b = 1'b0;
        foreach (imem[i]) begin
            imem[i] = '0;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            reset_with_program(t);
            @(negedge clk);                 // Outputs settled mid-cycle
            for (int w = 0; w < write_count[t]; w++) begin
                wait_writeback(test_name[t]);
                check_rd(test_name[t], exp_rd[t][w], wb_rd);
                check_data(test_name[t], exp_data[t][w], wb_data);
                @(negedge clk);
            end
            // Killed or skipped instructions must stay silent
            repeat (QUIET_CYCLES) begin
                if (wb_write !== 1'b0) begin
                    $display("Extra writeback in %s to x%0d", test_name[t], wb_rd);
                    abort_run("unexpected writeback");
                end
                @(negedge clk);
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+bench
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/regfile.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/pipeline_cpu.sv
bench/tb_pipeline_cpu.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_pipeline_cpu
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o sim_$(TOP)
	-./$(OBJ_DIR)/sim_$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "test passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
